//--- rv_core.f
common/rv_core_pkg.sv
fetch/fetch_unit.sv
source/stage_register.sv
decode/decode_unit.sv
source/register_file.sv
execute/execute_unit.sv
source/rv_core.sv
testbench/clock_gen.sv
testbench/rv_core_tb.sv

//--- Makefile
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f rv_core.f \
		--top-module rv_core_tb -Mdir obj_dir
	./obj_dir/Vrv_core_tb | tee $(LOG)
	grep -q "^TEST PASS$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- testbench/rv_core_tb.sv
module rv_core_tb
	import rv_core_pkg::*;
;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int addr_bits = 30;
	localparam logic [31:0] reset_pc = 32'h0;
	localparam int prog_len = 44;
	localparam int n_expected = 14;
	localparam int cycle_limit = prog_len * 8 + 100;

	logic clock, rst;
	logic [31:0] pc_out;
	logic inst_strobe, inst_ack;
	inst_t inst_in;
	logic [addr_bits-1:0] addr;
	logic [31:0] data_out;
	logic [3:0] select;
	logic write, data_strobe, data_ack;

	logic [31:0] rom [64];
	logic [addr_bits-1:0] exp_addr [n_expected];
	logic [31:0] exp_data [n_expected];

	int seed = 83824;
	int error_count = 0;
	int store_count = 0;
	int cycle_count = 0;
	int wait_left = -1;
	logic watch = 1'b0;
	logic rst_sampled = 1'b1;
	logic rst_prev = 1'b1;
	logic [addr_bits-1:0] saved_addr;
	logic [31:0] saved_data;
	logic [3:0] saved_select;
	logic saved_write;

	clock_gen clock_gen_i (.clock, .rst);

	rv_core #(.addr_bits(addr_bits), .reset_pc(reset_pc)) rv_core_i (
		.clock, .rst, .pc_out, .inst_strobe, .inst_in, .inst_ack,
		.addr, .data_out, .select, .write, .data_strobe, .data_ack
	);

	// Instruction encoders for the RV32I formats
	function automatic logic [31:0] i_format(input logic [31:0] imm, input logic [4:0] rs1,
			input logic [2:0] f3, input logic [4:0] rd);
		return {imm[11:0], rs1, f3, rd, 7'b0010011};
	endfunction

	function automatic logic [31:0] r_format(input logic [6:0] f7, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, 7'b0110011};
	endfunction

	function automatic logic [31:0] s_format(input logic [31:0] imm, input logic [4:0] rs2,
			input logic [4:0] rs1);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
	endfunction

	function automatic logic [31:0] b_format(input logic [31:0] imm, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
	endfunction

	function automatic logic [31:0] j_format(input logic [31:0] imm, input logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
	endfunction

	function automatic logic [31:0] u_format(input logic [19:0] imm, input logic [4:0] rd);
		return {imm, rd, 7'b0110111};
	endfunction

	task automatic expect_store(input int index, input logic [addr_bits-1:0] word,
			input logic [31:0] data);
		exp_addr[index] = word;
		exp_data[index] = data;
	endtask

	initial begin
		// Unused words hold a no-op tagged with their own index
		for (int i = 0; i < 64; i++)
			rom[i] = i_format(i, 5'd0, 3'b000, 5'd0);
		rom[0]  = i_format(5, 0, 3'b000, 1);
		rom[1]  = i_format(-3, 0, 3'b000, 2);
		rom[2]  = s_format(0, 1, 0);
		rom[3]  = s_format(4, 2, 0);
		rom[4]  = u_format(20'h12345, 3);
		rom[5]  = i_format(32'h678, 3, 3'b110, 3);
		rom[6]  = s_format(8, 3, 0);
		rom[7]  = i_format(4, 3, 3'b001, 4);
		rom[8]  = i_format(32'h401, 2, 3'b101, 5);
		rom[9]  = i_format(28, 2, 3'b101, 6);
		rom[10] = s_format(12, 4, 0);
		rom[11] = s_format(16, 5, 0);
		rom[12] = s_format(20, 6, 0);
		rom[13] = i_format(0, 2, 3'b010, 7);
		rom[14] = i_format(3, 1, 3'b011, 8);
		rom[15] = i_format(32'hff, 1, 3'b100, 9);
		rom[16] = i_format(32'hff, 3, 3'b111, 10);
		rom[17] = s_format(24, 7, 0);
		rom[18] = s_format(28, 8, 0);
		// Dependent chain through forwarding and bypass
		rom[19] = r_format(7'h00, 2, 1, 3'b000, 11);
		rom[20] = r_format(7'h20, 1, 11, 3'b000, 12);
		rom[21] = r_format(7'h00, 3, 12, 3'b100, 13);
		rom[22] = s_format(32, 13, 0);
		rom[23] = r_format(7'h00, 6, 1, 3'b001, 14);
		rom[24] = r_format(7'h00, 1, 2, 3'b010, 15);
		rom[25] = r_format(7'h00, 1, 2, 3'b011, 16);
		rom[26] = r_format(7'h00, 15, 14, 3'b110, 17);
		rom[27] = s_format(36, 17, 0);
		rom[28] = s_format(40, 16, 0);
		// Shadow stores of taken branches must never reach the bus
		rom[29] = b_format(8, 1, 1, 3'b000);
		rom[30] = s_format(44, 1, 0);
		rom[31] = b_format(8, 2, 1, 3'b001);
		rom[32] = s_format(48, 1, 0);
		rom[33] = b_format(8, 2, 1, 3'b100);
		rom[34] = s_format(52, 9, 0);
		rom[35] = b_format(8, 2, 1, 3'b110);
		rom[36] = s_format(56, 1, 0);
		rom[37] = b_format(12, 1, 2, 3'b101);
		rom[38] = b_format(8, 2, 1, 3'b111);
		rom[39] = j_format(8, 18);
		rom[40] = s_format(60, 1, 0);
		rom[41] = s_format(64, 18, 0);
		rom[42] = s_format(68, 10, 0);
		rom[43] = j_format(0, 0);

		expect_store(0, 0, 32'h00000005);
		expect_store(1, 1, 32'hfffffffd);
		expect_store(2, 2, 32'h12345678);
		expect_store(3, 3, 32'h23456780);
		expect_store(4, 4, 32'hfffffffe);
		expect_store(5, 5, 32'h0000000f);
		expect_store(6, 6, 32'h00000001);
		expect_store(7, 7, 32'h00000000);
		expect_store(8, 8, 32'hedcba985);
		expect_store(9, 9, 32'h00028001);
		expect_store(10, 10, 32'h00000000);
		expect_store(11, 13, 32'h000000fa);
		// Link of the jal at 0x9c
		expect_store(12, 16, 32'h000000a0);
		expect_store(13, 17, 32'h00000078);
	end

	always @(posedge clock)
		cycle_count++;

	// Reset as the DUT saw it at the last rising edge
	always @(posedge clock)
		rst_sampled <= rst;

	// Instruction ack arrives on about three cycles out of four
	initial begin
		inst_ack = 1'b0;
		inst_in = '0;
	end
	always @(negedge clock) begin
		inst_in = inst_t'(rom[pc_out[7:2]]);
		if (rst_sampled)
			inst_ack = 1'b0;
		else
			inst_ack = ($unsigned($random(seed)) % 4) != 0;
	end

	// Data bus model and store checks
	initial data_ack = 1'b0;
	always @(negedge clock) begin
		if (rst_sampled) begin
			data_ack = 1'b0;
			wait_left = -1;
			watch = 1'b0;
		end else begin
			if (watch) begin
				assert (addr == saved_addr) else begin
					error_count++;
					$display("[FAIL] addr got %h expected %h", addr, saved_addr);
				end
				assert (data_out == saved_data) else begin
					error_count++;
					$display("[FAIL] data_out got %h expected %h", data_out, saved_data);
				end
				assert (select == saved_select) else begin
					error_count++;
					$display("[FAIL] select got %h expected %h", select, saved_select);
				end
				assert (write == saved_write) else begin
					error_count++;
					$display("[FAIL] write got %h expected %h", write, saved_write);
				end
			end
			if (data_ack) begin
				data_ack = 1'b0;
			end else if (data_strobe) begin
				if (wait_left < 0)
					wait_left = $unsigned($random(seed)) % 4;
				if (wait_left == 0) begin
					data_ack = 1'b1;
					wait_left = -1;
					log_store();
				end else begin
					wait_left--;
				end
			end
			watch = data_strobe && !data_ack;
			saved_addr = addr;
			saved_data = data_out;
			saved_select = select;
			saved_write = write;
		end
	end

	task automatic log_store();
		if (store_count >= n_expected) begin
			error_count++;
			$display("Unexpected extra store to word %h with data %h", addr, data_out);
		end else begin
			assert (addr == exp_addr[store_count]) else begin
				error_count++;
				$display("[FAIL] addr got %h expected %h", addr, exp_addr[store_count]);
			end
			assert (data_out == exp_data[store_count]) else begin
				error_count++;
				$display("[FAIL] data_out got %h expected %h", data_out,
					exp_data[store_count]);
			end
			assert (select == 4'hf) else begin
				error_count++;
				$display("[FAIL] select got %h expected %h", select, 4'hf);
			end
			assert (write == 1'b1) else begin
				error_count++;
				$display("[FAIL] write got %h expected %h", write, 1'b1);
			end
		end
		store_count++;
	endtask

	// Bus outputs in reset and in the first cycle after it
	always @(negedge clock) begin
		if (rst_sampled) begin
			assert (inst_strobe == 1'b0) else begin
				error_count++;
				$display("[FAIL] inst_strobe got %h expected %h", inst_strobe, 1'b0);
			end
		end else if (rst_prev) begin
			assert (data_strobe == 1'b0) else begin
				error_count++;
				$display("[FAIL] data_strobe got %h expected %h", data_strobe, 1'b0);
			end
			assert (write == 1'b0) else begin
				error_count++;
				$display("[FAIL] write got %h expected %h", write, 1'b0);
			end
			assert (pc_out == reset_pc) else begin
				error_count++;
				$display("[FAIL] pc_out got %h expected %h", pc_out, reset_pc);
			end
			assert (inst_strobe == 1'b1) else begin
				error_count++;
				$display("[FAIL] inst_strobe got %h expected %h", inst_strobe, 1'b1);
			end
		end
		rst_prev = rst_sampled;
	end

	assert property (@(posedge clock) disable iff (rst)
		(data_strobe && !data_ack) |=> data_strobe)
	else begin
		error_count++;
		$display("data_strobe dropped before data_ack");
	end

	assert property (@(posedge clock) disable iff (rst) data_ack |=> !data_strobe)
	else begin
		error_count++;
		$display("data_strobe stayed high after data_ack");
	end

	initial begin
		@(negedge rst);
		while (store_count < n_expected && cycle_count < cycle_limit)
			@(negedge clock);
		if (store_count < n_expected) begin
			error_count++;
			$display("Timeout after %0d cycles with %0d stores seen", cycle_count,
				store_count);
		end else begin
			// Let any stray store show up
			repeat (20) @(negedge clock);
		end
		$display("errors %0d, stores %0d of %0d", error_count, store_count, n_expected);
		if (error_count == 0 && store_count == n_expected)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

//--- testbench/clock_gen.sv
module clock_gen (
	output logic clock,
	output logic rst
);
	timeunit 1ns;
	timeprecision 1ps;

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	// Reset spans the first two rising edges, released on a falling edge
	initial begin
		rst = 1'b1;
		repeat (2) @(posedge clock);
		@(negedge clock);
		rst = 1'b0;
	end

endmodule

//--- source/rv_core.sv
module rv_core
	import rv_core_pkg::*;
#(
	parameter int              addr_bits = 30,
	parameter logic [xlen-1:0] reset_pc  = '0
) (
	input  logic                 clock,
	input  logic                 rst,
	output logic [xlen-1:0]      pc_out,
	output logic                 inst_strobe,
	input  inst_t                inst_in,
	input  logic                 inst_ack,
	output logic [addr_bits-1:0] addr,
	output logic [xlen-1:0]      data_out,
	output logic [3:0]           select,
	output logic                 write,
	output logic                 data_strobe,
	input  logic                 data_ack
);

	logic            stall;
	logic            take_jump;
	logic [xlen-1:0] jump_target;

	logic            fetch_valid, fetched_valid;
	fetch_item_t     fetch_item, fetched_item;
	logic            decode_valid, decoded_valid;
	decode_item_t    decode_item, decoded_item;

	reg_index_t      rd_index_1, rd_index_2;
	logic [xlen-1:0] rd_value_1, rd_value_2;
	logic            wr_en;
	reg_index_t      wr_index;
	logic [xlen-1:0] wr_value;

	fetch_unit #(.reset_pc(reset_pc)) fetch_unit_i (
		.clock, .rst, .inst_in, .inst_ack, .pc_out, .inst_strobe,
		.stall, .take_jump, .jump_target,
		.item_valid(fetch_valid), .item(fetch_item)
	);

	stage_register #(.payload_t(fetch_item_t)) fetch_buffer (
		.clock, .rst, .hold(stall), .flush(take_jump),
		.in_valid(fetch_valid), .in_item(fetch_item),
		.out_valid(fetched_valid), .out_item(fetched_item)
	);

	decode_unit decode_unit_i (
		.in_valid(fetched_valid), .in_item(fetched_item),
		.rd_index_1, .rd_index_2, .rd_value_1, .rd_value_2,
		.out_valid(decode_valid), .out_item(decode_item)
	);

	stage_register #(.payload_t(decode_item_t)) decode_buffer (
		.clock, .rst, .hold(stall), .flush(take_jump),
		.in_valid(decode_valid), .in_item(decode_item),
		.out_valid(decoded_valid), .out_item(decoded_item)
	);

	register_file register_file_i (
		.clock, .rst, .rd_index_1, .rd_index_2, .rd_value_1, .rd_value_2,
		.wr_en, .wr_index, .wr_value
	);

	execute_unit #(.addr_bits(addr_bits)) execute_unit_i (
		.clock, .rst, .in_valid(decoded_valid), .in_item(decoded_item),
		.stall, .take_jump, .jump_target, .wr_en, .wr_index, .wr_value,
		.addr, .data_out, .select, .write, .data_strobe, .data_ack
	);

endmodule

//--- execute/execute_unit.sv
module execute_unit
	import rv_core_pkg::*;
#(
	parameter int addr_bits = 30
) (
	input  logic                 clock,
	input  logic                 rst,
	input  logic                 in_valid,
	input  decode_item_t         in_item,
	output logic                 stall,
	output logic                 take_jump,
	output logic [xlen-1:0]      jump_target,
	output logic                 wr_en,
	output reg_index_t           wr_index,
	output logic [xlen-1:0]      wr_value,
	output logic [addr_bits-1:0] addr,
	output logic [xlen-1:0]      data_out,
	output logic [3:0]           select,
	output logic                 write,
	output logic                 data_strobe,
	input  logic                 data_ack
);

	logic            await_ack;
	logic            active;
	logic            prev_valid;
	reg_index_t      prev_rd;
	logic [xlen-1:0] prev_result;
	logic [xlen-1:0] left, right, operand_b, result, full_addr;
	logic            condition;

	assign stall = await_ack;
	assign active = in_valid && !await_ack;

	// Forward the last written result when the indices match
	assign left = (prev_valid && prev_rd != '0 && prev_rd == in_item.rs_1)
		? prev_result : in_item.value_1;
	assign right = (prev_valid && prev_rd != '0 && prev_rd == in_item.rs_2)
		? prev_result : in_item.value_2;
	assign operand_b = in_item.use_imm ? in_item.imm : right;

	always_comb begin
		case (in_item.alu_op)
			alu_add:  result = left + operand_b;
			alu_sub:  result = left - operand_b;
			alu_sll:  result = left << operand_b[4:0];
			alu_slt:  result = xlen'($signed(left) < $signed(operand_b));
			alu_sltu: result = xlen'(left < operand_b);
			alu_xor:  result = left ^ operand_b;
			alu_srl:  result = left >> operand_b[4:0];
			alu_sra:  result = $signed(left) >>> operand_b[4:0];
			alu_or:   result = left | operand_b;
			alu_and:  result = left & operand_b;
			alu_pass: result = operand_b;
			default:  result = '0;
		endcase
	end

	always_comb begin
		case (in_item.branch_op)
			br_beq:  condition = left == right;
			br_bne:  condition = left != right;
			br_blt:  condition = $signed(left) < $signed(right);
			br_bge:  condition = $signed(left) >= $signed(right);
			br_bltu: condition = left < right;
			br_bgeu: condition = left >= right;
			default: condition = 1'b0;
		endcase
	end

	assign take_jump = active && (in_item.is_jal || condition);
	assign jump_target = in_item.pc + in_item.imm;

	assign wr_en = active && in_item.writes_rd;
	assign wr_index = in_item.rd;
	assign wr_value = result;

	assign full_addr = left + in_item.imm;

	// Every data access is a full word store
	assign select = 4'b1111;
	assign write = data_strobe;

	always_ff @(posedge clock) begin
		if (rst) begin
			await_ack <= 1'b0;
			data_strobe <= 1'b0;
			prev_valid <= 1'b0;
		end else begin
			if (active && in_item.is_store) begin
				await_ack <= 1'b1;
				data_strobe <= 1'b1;
			end else if (await_ack && data_ack) begin
				await_ack <= 1'b0;
				data_strobe <= 1'b0;
			end
			if (wr_en)
				prev_valid <= 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (active && in_item.is_store) begin
			addr <= full_addr[addr_bits+1:2];
			data_out <= right;
		end
		if (wr_en) begin
			prev_rd <= wr_index;
			prev_result <= result;
		end
	end

endmodule

//--- source/register_file.sv
module register_file
	import rv_core_pkg::*;
(
	input  logic            clock,
	input  logic            rst,
	input  reg_index_t      rd_index_1,
	input  reg_index_t      rd_index_2,
	output logic [xlen-1:0] rd_value_1,
	output logic [xlen-1:0] rd_value_2,
	input  logic            wr_en,
	input  reg_index_t      wr_index,
	input  logic [xlen-1:0] wr_value
);

	logic [xlen-1:0] registers [32];

	always_ff @(posedge clock) begin
		if (rst) begin
			for (int i = 0; i < 32; i++)
				registers[i] <= '0;
		end else if (wr_en && wr_index != '0) begin
			registers[wr_index] <= wr_value;
		end
	end

	// x0 reads zero, a same-cycle write is seen by the reader
	always_comb begin
		if (rd_index_1 == '0)
			rd_value_1 = '0;
		else if (wr_en && wr_index == rd_index_1)
			rd_value_1 = wr_value;
		else
			rd_value_1 = registers[rd_index_1];

		if (rd_index_2 == '0)
			rd_value_2 = '0;
		else if (wr_en && wr_index == rd_index_2)
			rd_value_2 = wr_value;
		else
			rd_value_2 = registers[rd_index_2];
	end

endmodule

//--- decode/decode_unit.sv
module decode_unit
	import rv_core_pkg::*;
(
	input  logic            in_valid,
	input  fetch_item_t     in_item,
	output reg_index_t      rd_index_1,
	output reg_index_t      rd_index_2,
	input  logic [xlen-1:0] rd_value_1,
	input  logic [xlen-1:0] rd_value_2,
	output logic            out_valid,
	output decode_item_t    out_item
);

	logic [31:0] raw;
	logic [xlen-1:0] imm_i, imm_s, imm_b, imm_j, imm_u;
	logic alt;

	function automatic alu_op_t alu_select(input logic [2:0] funct_3, input logic alt_form,
			input logic reg_form);
		alu_op_t op;
		case (funct_3)
			f3_add:  op = (alt_form && reg_form) ? alu_sub : alu_add;
			f3_sll:  op = alu_sll;
			f3_slt:  op = alu_slt;
			f3_sltu: op = alu_sltu;
			f3_xor:  op = alu_xor;
			f3_srl:  op = alt_form ? alu_sra : alu_srl;
			f3_or:   op = alu_or;
			f3_and:  op = alu_and;
			default: op = alu_add;
		endcase
		return op;
	endfunction

	assign raw = in_item.inst;
	assign alt = in_item.inst.funct_7[5];

	// Immediate formats
	assign imm_i = {{20{raw[31]}}, raw[31:20]};
	assign imm_s = {{20{raw[31]}}, raw[31:25], raw[11:7]};
	assign imm_b = {{19{raw[31]}}, raw[31], raw[7], raw[30:25], raw[11:8], 1'b0};
	assign imm_j = {{11{raw[31]}}, raw[31], raw[19:12], raw[20], raw[30:21], 1'b0};
	assign imm_u = {raw[31:12], 12'b0};

	assign rd_index_1 = in_item.inst.rs_1;
	assign rd_index_2 = in_item.inst.rs_2;

	assign out_valid = in_valid;

	always_comb begin
		out_item = '0;
		out_item.pc = in_item.pc;
		out_item.value_1 = rd_value_1;
		out_item.value_2 = rd_value_2;
		out_item.rs_1 = in_item.inst.rs_1;
		out_item.rs_2 = in_item.inst.rs_2;
		out_item.rd = in_item.inst.rd;
		out_item.imm = imm_i;
		out_item.alu_op = alu_add;
		out_item.branch_op = br_none;

		case (in_item.inst.op)
			op_lui: begin
				out_item.imm = imm_u;
				out_item.alu_op = alu_pass;
				out_item.use_imm = 1'b1;
				out_item.writes_rd = 1'b1;
			end
			op_jal: begin
				out_item.imm = imm_j;
				// Link value rides in the second operand, clear index so nothing forwards
				out_item.value_2 = in_item.pc + 32'd4;
				out_item.rs_2 = '0;
				out_item.alu_op = alu_pass;
				out_item.is_jal = 1'b1;
				out_item.writes_rd = 1'b1;
			end
			op_branch: begin
				out_item.imm = imm_b;
				case (in_item.inst.funct_3)
					f3_beq:  out_item.branch_op = br_beq;
					f3_bne:  out_item.branch_op = br_bne;
					f3_blt:  out_item.branch_op = br_blt;
					f3_bge:  out_item.branch_op = br_bge;
					f3_bltu: out_item.branch_op = br_bltu;
					f3_bgeu: out_item.branch_op = br_bgeu;
					default: out_item.branch_op = br_none;
				endcase
			end
			op_store: begin
				out_item.imm = imm_s;
				out_item.is_store = 1'b1;
			end
			op_alu_imm: begin
				out_item.alu_op = alu_select(in_item.inst.funct_3, alt, 1'b0);
				out_item.use_imm = 1'b1;
				out_item.writes_rd = 1'b1;
			end
			op_alu_reg: begin
				out_item.alu_op = alu_select(in_item.inst.funct_3, alt, 1'b1);
				out_item.writes_rd = 1'b1;
			end
			default: begin
				// Unsupported opcodes pass through as no-ops
				out_item.writes_rd = 1'b0;
			end
		endcase
	end

endmodule

//--- source/stage_register.sv
module stage_register #(
	parameter type payload_t = logic
) (
	input  logic     clock,
	input  logic     rst,
	input  logic     hold,
	input  logic     flush,
	input  logic     in_valid,
	input  payload_t in_item,
	output logic     out_valid,
	output payload_t out_item
);

	always_ff @(posedge clock) begin
		if (rst) begin
			out_valid <= 1'b0;
		end else if (!hold) begin
			// Flush drops whatever arrives this cycle
			out_valid <= in_valid && !flush;
		end
	end

	always_ff @(posedge clock) begin
		if (!hold)
			out_item <= in_item;
	end

endmodule

//--- fetch/fetch_unit.sv
module fetch_unit
	import rv_core_pkg::*;
#(
	parameter logic [xlen-1:0] reset_pc = '0
) (
	input  logic            clock,
	input  logic            rst,
	input  inst_t           inst_in,
	input  logic            inst_ack,
	output logic [xlen-1:0] pc_out,
	output logic            inst_strobe,
	input  logic            stall,
	input  logic            take_jump,
	input  logic [xlen-1:0] jump_target,
	output logic            item_valid,
	output fetch_item_t     item
);

	logic [xlen-1:0] pc;
	logic            started;
	logic            discard;
	logic            delivered;

	// No request in the first cycle out of reset or while execute is stalled
	assign inst_strobe = started && !stall;
	assign delivered = inst_strobe && inst_ack;
	assign pc_out = pc;

	assign item_valid = delivered && !discard;
	assign item = '{pc: pc, inst: inst_in};

	always_ff @(posedge clock) begin
		if (rst) begin
			pc <= reset_pc;
			started <= 1'b0;
			discard <= 1'b0;
		end else begin
			started <= 1'b1;
			if (take_jump) begin
				pc <= jump_target;
				// A request still open at the old pc may complete late
				discard <= inst_strobe && !inst_ack;
			end else if (delivered) begin
				// Dropped word is fetched again from the same pc
				if (!discard)
					pc <= pc + 32'd4;
				discard <= 1'b0;
			end
		end
	end

endmodule

//--- common/rv_core_pkg.sv
package rv_core_pkg;

	localparam int xlen = 32;

	// Standard 32-bit instruction layout, low two bits are always 11
	typedef struct packed {
		logic [6:0] funct_7;
		logic [4:0] rs_2;
		logic [4:0] rs_1;
		logic [2:0] funct_3;
		logic [4:0] rd;
		logic [4:0] op;
		logic [1:0] low;
	} inst_t;

	typedef logic [4:0] reg_index_t;

	// Major opcodes, bits 6:2 of the instruction
	localparam logic [4:0] op_lui     = 5'b01101;
	localparam logic [4:0] op_jal     = 5'b11011;
	localparam logic [4:0] op_branch  = 5'b11000;
	localparam logic [4:0] op_store   = 5'b01000;
	localparam logic [4:0] op_alu_imm = 5'b00100;
	localparam logic [4:0] op_alu_reg = 5'b01100;

	// ALU funct_3 values
	localparam logic [2:0] f3_add  = 3'b000;
	localparam logic [2:0] f3_sll  = 3'b001;
	localparam logic [2:0] f3_slt  = 3'b010;
	localparam logic [2:0] f3_sltu = 3'b011;
	localparam logic [2:0] f3_xor  = 3'b100;
	localparam logic [2:0] f3_srl  = 3'b101;
	localparam logic [2:0] f3_or   = 3'b110;
	localparam logic [2:0] f3_and  = 3'b111;

	// Branch funct_3 values
	localparam logic [2:0] f3_beq  = 3'b000;
	localparam logic [2:0] f3_bne  = 3'b001;
	localparam logic [2:0] f3_blt  = 3'b100;
	localparam logic [2:0] f3_bge  = 3'b101;
	localparam logic [2:0] f3_bltu = 3'b110;
	localparam logic [2:0] f3_bgeu = 3'b111;

	typedef enum logic [3:0] {
		alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor,
		alu_srl, alu_sra, alu_or, alu_and, alu_pass
	} alu_op_t;

	typedef enum logic [2:0] {
		br_none, br_beq, br_bne, br_blt, br_bge, br_bltu, br_bgeu
	} branch_op_t;

	typedef struct packed {
		logic [xlen-1:0] pc;
		inst_t           inst;
	} fetch_item_t;

	typedef struct packed {
		logic [xlen-1:0] pc;
		logic [xlen-1:0] value_1;
		logic [xlen-1:0] value_2;
		reg_index_t      rs_1;
		reg_index_t      rs_2;
		reg_index_t      rd;
		logic [xlen-1:0] imm;
		alu_op_t         alu_op;
		branch_op_t      branch_op;
		logic            use_imm;
		logic            is_jal;
		logic            is_store;
		logic            writes_rd;
	} decode_item_t;

endpackage
